// File: build.f
+incdir+verif
design/pllCfgPkg.sv
design/pllAddrDecoder.sv
design/pllRegBank.sv
design/pllSerialLoader.sv
design/pllCfgTop.sv
verif/pllCfgTb.sv

// File: design/pllAddrDecoder.sv
`default_nettype none
`timescale 1ns/10ps

module pllAddrDecoder (
    input  logic [pllCfgPkg::ADDR_W-1:0]   addr,
    input  logic [pllCfgPkg::DATA_W-1:0]   readWords [pllCfgPkg::NUM_PLLS],
    output logic [pllCfgPkg::NUM_PLLS-1:0] bankSel,
    output logic [2:0]                     regIndex,
    output logic [pllCfgPkg::DATA_W-1:0]   dataOut
);

    import pllCfgPkg::*;

    logic       inSpace;
    logic [2:0] devField;

    // Top bits pick the loader space; the rest split device and register.
    assign inSpace  = (addr[ADDR_W-1:6] == PLL_SPACE_BASE);
    assign devField = addr[5:3];
    assign regIndex = addr[2:0];

    // ==================================================
    // Device select
    // ==================================================
    always_comb begin
        for (int i = 0; i < NUM_PLLS; i++) begin
            bankSel[i] = inSpace && (devField == 3'(i));  // Devices 3+ select nothing.
        end
    end

    // ==================================================
    // Readback mux
    // ==================================================
    always_comb begin
        dataOut = '0;  // Unselected address reads zero.
        for (int i = 0; i < NUM_PLLS; i++) begin
            if (bankSel[i]) begin
                dataOut = readWords[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pllCfgPkg.sv
`default_nettype none

package pllCfgPkg;

    // ==================================================
    // Bus and address map
    // ==================================================
    localparam int NUM_PLLS = 3;
    localparam int ADDR_W = 13;
    localparam int DATA_W = 32;

    localparam logic [6:0] PLL_SPACE_BASE = 7'h12;  // Matches addr[12:6].

    localparam logic [2:0] REG_BITS_0TO31   = 3'd0;
    localparam logic [2:0] REG_BITS_68TO99  = 3'd1;
    localparam logic [2:0] REG_BITS_100TO131 = 3'd2;
    localparam logic [2:0] REG_CONTROL      = 3'd3;
    localparam logic [2:0] REG_XFER         = 3'd4;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_BUSY_BIT   = 1;
    localparam int CTRL_RESET_BIT  = 2;

    // ==================================================
    // Serial frame and timing
    // ==================================================
    localparam int FRAME_W = 132;
    localparam int PAD_W = 36;
    localparam int BIT_CNT_W = $clog2(FRAME_W);

    localparam int SCK_DIV = 4;  // busClk cycles per SCK period.
    localparam int SCK_CNT_W = $clog2(SCK_DIV);

    // Loader states.
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ALIGN  = 2'd1;
    localparam logic [1:0] ST_SHIFT  = 2'd2;
    localparam logic [1:0] ST_STROBE = 2'd3;

    // Bank builds the fields, loader shifts the raw word.
    typedef union packed {
        struct packed {
            logic [31:0]      bits100to131;
            logic [31:0]      bits68to99;
            logic [PAD_W-1:0] pad;
            logic [31:0]      bits0to31;
        } fields;
        logic [FRAME_W-1:0] raw;
    } pllFrame_u;

endpackage

`default_nettype wire

// File: design/pllCfgTop.sv
`default_nettype none
`timescale 1ns/10ps

module pllCfgTop (
    input  logic                           busClk,
    input  logic                           xferDone,
    input  logic [pllCfgPkg::ADDR_W-1:0]   addr,
    input  logic [pllCfgPkg::DATA_W-1:0]   dataIn,
    input  logic                           wr0,
    input  logic                           wr1,
    input  logic                           wr2,
    input  logic                           wr3,
    output logic [pllCfgPkg::DATA_W-1:0]   dataOut,
    output logic                           sck,
    output logic                           sdi,
    output logic [pllCfgPkg::NUM_PLLS-1:0] chipSel,
    output logic [pllCfgPkg::NUM_PLLS-1:0] pllEnable,
    output logic [pllCfgPkg::NUM_PLLS-1:0] pllReset,
    output logic                           loadDone
);

    import pllCfgPkg::*;

    logic [NUM_PLLS-1:0] bankSel;
    logic [2:0]          regIndex;
    logic [DATA_W-1:0]   readWords [NUM_PLLS];
    logic [NUM_PLLS-1:0] loadReq;
    logic [NUM_PLLS-1:0] loadGrant;
    logic [NUM_PLLS-1:0] busyMask;
    pllFrame_u           frames [NUM_PLLS];

    pllAddrDecoder pllAddrDecoder_inst (
        .addr      (addr),
        .readWords (readWords),
        .bankSel   (bankSel),
        .regIndex  (regIndex),
        .dataOut   (dataOut)
    );

    // ==================================================
    // One register bank per synthesizer
    // ==================================================
    for (genvar i = 0; i < NUM_PLLS; i++) begin : genBank
        pllRegBank pllRegBank_inst (
            .busClk     (busClk),
            .xferDone   (xferDone),
            .bankSelect (bankSel[i]),
            .regIndex   (regIndex),
            .dataIn     (dataIn),
            .wr0        (wr0),
            .wr1        (wr1),
            .wr2        (wr2),
            .wr3        (wr3),
            .loadGrant  (loadGrant[i]),
            .busy       (busyMask[i]),
            .readWord   (readWords[i]),
            .frame      (frames[i]),
            .loadReq    (loadReq[i]),
            .pllEnable  (pllEnable[i]),
            .pllReset   (pllReset[i])
        );
    end

    pllSerialLoader pllSerialLoader_inst (
        .busClk    (busClk),
        .xferDone  (xferDone),
        .loadReq   (loadReq),
        .frames    (frames),
        .loadGrant (loadGrant),
        .busyMask  (busyMask),
        .chipSel   (chipSel),
        .sck       (sck),
        .sdi       (sdi),
        .loadDone  (loadDone)
    );

endmodule

`default_nettype wire

// File: design/pllRegBank.sv
`default_nettype none
`timescale 1ns/10ps

module pllRegBank (
    input  logic                         busClk,
    input  logic                         xferDone,
    input  logic                         bankSelect,
    input  logic [2:0]                   regIndex,
    input  logic [pllCfgPkg::DATA_W-1:0] dataIn,
    input  logic                         wr0,
    input  logic                         wr1,
    input  logic                         wr2,
    input  logic                         wr3,
    input  logic                         loadGrant,
    input  logic                         busy,
    output logic [pllCfgPkg::DATA_W-1:0] readWord,
    output pllCfgPkg::pllFrame_u         frame,
    output logic                         loadReq,
    output logic                         pllEnable,
    output logic                         pllReset
);

    import pllCfgPkg::*;

    logic [31:0] bits0to31;
    logic [31:0] bits68to99;
    logic [31:0] bits100to131;
    logic [3:0]  laneWr;
    logic [31:0] ctrlWord;

    assign laneWr = {wr3, wr2, wr1, wr0};

    // ==================================================
    // Configuration words, byte-lane writes
    // ==================================================
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            bits0to31    <= '0;
            bits68to99   <= '0;
            bits100to131 <= '0;
        end else if (bankSelect) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneWr[lane]) begin
                    case (regIndex)
                        REG_BITS_0TO31:    bits0to31[lane*8 +: 8] <= dataIn[lane*8 +: 8];
                        REG_BITS_68TO99:   bits68to99[lane*8 +: 8] <= dataIn[lane*8 +: 8];
                        REG_BITS_100TO131: bits100to131[lane*8 +: 8] <= dataIn[lane*8 +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    // Control pins, lane 0 only.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            pllEnable <= 1'b0;
            pllReset  <= 1'b0;
        end else if (bankSelect && wr0 && (regIndex == REG_CONTROL)) begin
            pllEnable <= dataIn[CTRL_ENABLE_BIT];
            pllReset  <= dataIn[CTRL_RESET_BIT];
        end
    end

    // Pending load request. A new write wins over a grant.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            loadReq <= 1'b0;
        end else if (bankSelect && wr3 && (regIndex == REG_XFER)) begin
            loadReq <= 1'b1;
        end else if (loadGrant) begin
            loadReq <= 1'b0;
        end
    end

    // ==================================================
    // Readback and frame
    // ==================================================
    always_comb begin
        ctrlWord = '0;
        ctrlWord[CTRL_ENABLE_BIT] = pllEnable;
        ctrlWord[CTRL_BUSY_BIT]   = busy;
        ctrlWord[CTRL_RESET_BIT]  = pllReset;
    end

    always_comb begin
        case (regIndex)
            REG_BITS_0TO31:    readWord = bits0to31;
            REG_BITS_68TO99:   readWord = bits68to99;
            REG_BITS_100TO131: readWord = bits100to131;
            REG_CONTROL:       readWord = ctrlWord;
            default:           readWord = '0;  // XFER reads zero.
        endcase
    end

    always_comb begin
        frame.fields.bits100to131 = bits100to131;
        frame.fields.bits68to99   = bits68to99;
        frame.fields.pad          = '0;
        frame.fields.bits0to31    = bits0to31;
    end

endmodule

`default_nettype wire

// File: design/pllSerialLoader.sv
`default_nettype none
`timescale 1ns/10ps

module pllSerialLoader (
    input  logic                           busClk,
    input  logic                           xferDone,
    input  logic [pllCfgPkg::NUM_PLLS-1:0] loadReq,
    input  pllCfgPkg::pllFrame_u           frames [pllCfgPkg::NUM_PLLS],
    output logic [pllCfgPkg::NUM_PLLS-1:0] loadGrant,
    output logic [pllCfgPkg::NUM_PLLS-1:0] busyMask,
    output logic [pllCfgPkg::NUM_PLLS-1:0] chipSel,
    output logic                           sck,
    output logic                           sdi,
    output logic                           loadDone
);

    import pllCfgPkg::*;

    logic [SCK_CNT_W-1:0] phaseCnt;
    logic                 riseTick;
    logic                 fallTick;
    logic                 sckEnable;

    logic [1:0]           state;
    logic [FRAME_W-1:0]   shiftReg;
    logic [BIT_CNT_W-1:0] bitCnt;

    logic [NUM_PLLS-1:0]  pickOneHot;
    pllFrame_u            pickFrame;

    // ==================================================
    // SCK generation
    // ==================================================
    assign riseTick = (phaseCnt == SCK_CNT_W'(SCK_DIV - 1));      // Next cycle is phase 0.
    assign fallTick = (phaseCnt == SCK_CNT_W'(SCK_DIV / 2 - 1));

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            phaseCnt <= '0;
        end else if (riseTick) begin
            phaseCnt <= '0;
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
        end
    end

    // High for the first half of the period, only while shifting.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            sck <= 1'b0;
        end else if (riseTick) begin
            sck <= sckEnable;
        end else if (fallTick) begin
            sck <= 1'b0;
        end
    end

    // ==================================================
    // Fixed-priority pick, lowest index wins
    // ==================================================
    always_comb begin
        pickOneHot = '0;
        pickFrame  = frames[0];
        for (int i = NUM_PLLS - 1; i >= 0; i--) begin
            if (loadReq[i]) begin
                pickOneHot = '0;
                pickOneHot[i] = 1'b1;
                pickFrame = frames[i];
            end
        end
    end

    // ==================================================
    // Load FSM
    // ==================================================
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            state     <= ST_IDLE;
            loadGrant <= '0;
            busyMask  <= '0;
            chipSel   <= '0;
            sckEnable <= 1'b0;
            sdi       <= 1'b0;
            loadDone  <= 1'b0;
            bitCnt    <= '0;
        end else begin
            loadGrant <= '0;
            loadDone  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (|loadReq) begin
                        loadGrant <= pickOneHot;
                        busyMask  <= pickOneHot;  // Doubles as the active device.
                        state     <= ST_ALIGN;
                    end
                end
                ST_ALIGN: begin
                    if (fallTick) begin
                        sdi       <= shiftReg[FRAME_W-1];  // Bit 131 first.
                        sckEnable <= 1'b1;
                        bitCnt    <= BIT_CNT_W'(FRAME_W - 1);
                        state     <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (fallTick) begin
                        if (bitCnt == '0) begin
                            sdi       <= 1'b0;
                            sckEnable <= 1'b0;
                            chipSel   <= busyMask;  // Latch pulse, one SCK period.
                            state     <= ST_STROBE;
                        end else begin
                            sdi    <= shiftReg[FRAME_W-1];
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                default: begin
                    if (fallTick) begin
                        chipSel  <= '0;
                        busyMask <= '0;
                        loadDone <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Frame register, captured at grant and drained MSB first.
    always_ff @(posedge busClk) begin
        if ((state == ST_IDLE) && (|loadReq)) begin
            shiftReg <= pickFrame.raw;
        end else if (fallTick && ((state == ST_ALIGN) || (state == ST_SHIFT))) begin
            shiftReg <= {shiftReg[FRAME_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module pllCfgTb -f build.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; }

// File: verif/pllCfgTbTasks.svh
`ifndef PLL_CFG_TB_TASKS_SVH
`define PLL_CFG_TB_TASKS_SVH

// ==================================================
// Bus access
// ==================================================
function automatic logic [ADDR_W-1:0] addrOf(input int dev, input logic [2:0] regIdx);
    return {PLL_SPACE_BASE, 3'(dev), regIdx};
endfunction

// Strobes stay up until the next bus task, so back-to-back calls land on consecutive edges.
task automatic busWrite(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                        input logic [3:0] lanes);
    @(posedge busClk);
    #1;
    addr   = a;
    dataIn = d;
    {wr3, wr2, wr1, wr0} = lanes;
endtask

task automatic busIdle();
    @(posedge busClk);
    #1;
    {wr3, wr2, wr1, wr0} = 4'b0000;
endtask

task automatic busRead(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    @(posedge busClk);
    #1;
    {wr3, wr2, wr1, wr0} = 4'b0000;
    addr = a;
    #2;
    d = dataOut;  // Combinational path has settled.
endtask

// ==================================================
// Serial side
// ==================================================
task automatic waitSckRise();
    logic prevSck;
    logic seen;
    int   cnt;
    prevSck = sck;
    seen    = 1'b0;
    cnt     = 0;
    while (!seen && cnt < 64) begin
        @(posedge busClk);
        #2;
        if (sck && !prevSck) seen = 1'b1;
        prevSck = sck;
        cnt++;
    end
    if (!seen) stopOnError("timed out waiting for a rising edge on sck");
endtask

task automatic waitLoadDone();
    logic seen;
    int   cnt;
    seen = 1'b0;
    cnt  = 0;
    while (!seen && cnt < 2000) begin
        @(posedge busClk);
        #2;
        if (loadDone) seen = 1'b1;
        cnt++;
    end
    if (!seen) stopOnError("timed out waiting for loadDone");
endtask

task automatic captureFrame(input int expDev, output pllFrame_u got);
    logic seen;
    int   cnt;
    got.raw = '0;
    for (int b = FRAME_W - 1; b >= 0; b--) begin
        waitSckRise();
        got.raw[b] = sdi;
        checkMask("chipSel", chipSel, '0);  // Quiet while shifting.
    end
    seen = 1'b0;
    cnt  = 0;
    while (!seen && cnt < 16) begin
        @(posedge busClk);
        #2;
        if (chipSel != '0) seen = 1'b1;
        cnt++;
    end
    if (!seen) stopOnError("no chip-select pulse after the last frame bit");
    checkMask("chipSel", chipSel, NUM_PLLS'(1) << expDev);
    waitLoadDone();
endtask

// ==================================================
// Compare tasks
// ==================================================
task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        stopOnError("pin mismatch");
    end
endtask

task automatic checkWord(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        stopOnError("word mismatch");
    end
endtask

task automatic checkMask(input string name, input logic [NUM_PLLS-1:0] got,
                         input logic [NUM_PLLS-1:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        stopOnError("pin mismatch");
    end
endtask

task automatic checkFrame(input string name, input pllFrame_u got, input pllFrame_u exp);
    if (got.raw !== exp.raw) begin
        $display("FAILED %s: got %h, expected %h", name, got.raw, exp.raw);
        stopOnError("serial frame mismatch");
    end
endtask

`endif

// File: verif/pllCfgTb.sv
`default_nettype none
`timescale 1ns/10ps

module pllCfgTb;

    import pllCfgPkg::*;

    logic                busClk;
    logic                xferDone;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   dataIn;
    logic                wr0, wr1, wr2, wr3;
    logic [DATA_W-1:0]   dataOut;
    logic                sck;
    logic                sdi;
    logic [NUM_PLLS-1:0] chipSel;
    logic [NUM_PLLS-1:0] pllEnable;
    logic [NUM_PLLS-1:0] pllReset;
    logic                loadDone;

    integer              seed = 32'hbd92_b298;
    logic [DATA_W-1:0]   shadow [NUM_PLLS][3];  // Expected config words per device.

    pllCfgTop pllCfgTop_inst (
        .busClk    (busClk),
        .xferDone  (xferDone),
        .addr      (addr),
        .dataIn    (dataIn),
        .wr0       (wr0),
        .wr1       (wr1),
        .wr2       (wr2),
        .wr3       (wr3),
        .dataOut   (dataOut),
        .sck       (sck),
        .sdi       (sdi),
        .chipSel   (chipSel),
        .pllEnable (pllEnable),
        .pllReset  (pllReset),
        .loadDone  (loadDone)
    );

    always #5 busClk = ~busClk;

    task automatic stopOnError(input string what);
        $display("Error: %s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    `include "pllCfgTbTasks.svh"

    // High words, 36 zeros, then the low word.
    function automatic pllFrame_u expectedFrame(input int dev);
        pllFrame_u f;
        f.raw = {shadow[dev][2], shadow[dev][1], {PAD_W{1'b0}}, shadow[dev][0]};
        return f;
    endfunction

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic testResetState();
        logic [DATA_W-1:0] rd;
        for (int d = 0; d < NUM_PLLS; d++) begin
            for (int r = 0; r < 5; r++) begin
                busRead(addrOf(d, 3'(r)), rd);
                checkWord("dataOut", rd, '0);
            end
        end
        busRead(13'h0123, rd);
        checkWord("dataOut outside space", rd, '0);
        checkMask("chipSel", chipSel, '0);
        checkMask("pllEnable", pllEnable, '0);
        checkMask("pllReset", pllReset, '0);
        checkBit("sck", sck, 1'b0);
    endtask

    task automatic testByteLanes();
        logic [DATA_W-1:0] wd;
        logic [DATA_W-1:0] rd;
        logic [3:0]        lanes;
        for (int d = 0; d < NUM_PLLS; d++) begin
            for (int r = 0; r < 3; r++) begin
                wd = $random(seed);
                busWrite(addrOf(d, 3'(r)), wd, 4'b1111);
                shadow[d][r] = wd;
                for (int k = 0; k < 3; k++) begin
                    wd    = $random(seed);
                    lanes = (k == 0) ? 4'(1 << r) : 4'($random(seed));
                    busWrite(addrOf(d, 3'(r)), wd, lanes);
                    for (int l = 0; l < 4; l++) begin
                        if (lanes[l]) shadow[d][r][l*8 +: 8] = wd[l*8 +: 8];
                    end
                    busRead(addrOf(d, 3'(r)), rd);
                    checkWord("config word", rd, shadow[d][r]);
                end
            end
        end
        // Neither a wrong base nor device field 3 hits a bank.
        busWrite({7'h13, 3'd0, 3'd0}, 32'hdead_beef, 4'b1111);
        busWrite({PLL_SPACE_BASE, 3'd3, 3'd1}, 32'hcafe_f00d, 4'b1111);
        busIdle();
        for (int d = 0; d < NUM_PLLS; d++) begin
            for (int r = 0; r < 3; r++) begin
                busRead(addrOf(d, 3'(r)), rd);
                checkWord("config word after stray write", rd, shadow[d][r]);
            end
        end
    endtask

    task automatic testControl();
        logic [DATA_W-1:0]   rd;
        logic [NUM_PLLS-1:0] enMask;
        enMask = '0;
        for (int d = 0; d < NUM_PLLS; d++) begin
            busWrite(addrOf(d, REG_CONTROL), 32'h5, 4'b0001);
            enMask[d] = 1'b1;  // Earlier devices stay enabled.
            busRead(addrOf(d, REG_CONTROL), rd);
            checkWord("control", rd, 32'h5);
            checkMask("pllEnable", pllEnable, enMask);
            checkMask("pllReset", pllReset, NUM_PLLS'(1) << d);
            busWrite(addrOf(d, REG_CONTROL), 32'h1, 4'b0001);
            busRead(addrOf(d, REG_CONTROL), rd);
            checkWord("control", rd, 32'h1);
            checkMask("pllReset", pllReset, '0);
        end
        checkMask("pllEnable", pllEnable, '1);
        busWrite(addrOf(1, REG_XFER), '0, 4'b1000);
        busIdle();
        repeat (3) @(posedge busClk);
        busRead(addrOf(1, REG_CONTROL), rd);
        checkWord("control busy", rd, 32'h3);
        waitLoadDone();
        busRead(addrOf(1, REG_CONTROL), rd);
        checkWord("control idle", rd, 32'h1);
    endtask

    task automatic testSerialLoad();
        pllFrame_u got;
        for (int d = 0; d < NUM_PLLS; d++) begin
            busWrite(addrOf(d, REG_XFER), '0, 4'b1000);
            busIdle();
            captureFrame(d, got);
            checkFrame("frame", got, expectedFrame(d));
        end
    endtask

    task automatic testArbitration();
        pllFrame_u expFrames [NUM_PLLS];
        pllFrame_u got [4];
        for (int d = 0; d < NUM_PLLS; d++) expFrames[d] = expectedFrame(d);
        busWrite(addrOf(1, REG_XFER), '0, 4'b1000);  // Keeps the loader busy.
        busIdle();
        fork
            begin
                captureFrame(1, got[0]);
                captureFrame(0, got[1]);
                captureFrame(1, got[2]);
                captureFrame(2, got[3]);
            end
            begin
                repeat (3) @(posedge busClk);
                busWrite(addrOf(2, REG_XFER), '0, 4'b1000);
                busWrite(addrOf(0, REG_XFER), '0, 4'b1000);
                busWrite(addrOf(1, REG_XFER), '0, 4'b1000);
                busIdle();
                waitLoadDone();
                repeat (12) @(posedge busClk);  // Device 0 now shifting.
                busWrite(addrOf(0, REG_BITS_0TO31), 32'h0f0f_a5a5, 4'b1111);
                busIdle();
            end
        join
        checkFrame("frame 1", got[0], expFrames[1]);
        checkFrame("frame 0", got[1], expFrames[0]);
        checkFrame("frame 1 again", got[2], expFrames[1]);
        checkFrame("frame 2", got[3], expFrames[2]);
    endtask

    // ==================================================
    // Sequence
    // ==================================================
    initial begin
        busClk   = 1'b0;
        xferDone = 1'b1;
        addr     = '0;
        dataIn   = '0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        for (int d = 0; d < NUM_PLLS; d++) begin
            for (int r = 0; r < 3; r++) shadow[d][r] = '0;
        end
        repeat (16) @(posedge busClk);
        #1;
        xferDone = 1'b0;

        testResetState();
        testByteLanes();
        testControl();
        testSerialLoad();
        testArbitration();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
